/* rtl/cca_pkg.sv */
package cca_pkg;

    // ----------------------------------------
    // sample path
    // ----------------------------------------
    localparam int SAMPLE_W     = 16;   // signed I or Q
    localparam int POWER_W      = 16;
    localparam int POWER_SHIFT  = 15;   // I^2 + Q^2 scaling before saturation

    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_LEVEL_W = 5;    // holds 0..FIFO_DEPTH

    // averaging window
    localparam int WINDOW_LOG2  = 4;
    localparam int WINDOW_LEN   = 1 << WINDOW_LOG2;

    // ----------------------------------------
    // APB register map
    // ----------------------------------------
    localparam int APB_ADDR_W   = 12;
    localparam int APB_DATA_W   = 32;

    localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 12'h000;
    localparam logic [APB_ADDR_W-1:0] REG_LIMITS = 12'h004;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 12'h008;
    localparam logic [APB_ADDR_W-1:0] REG_POWER  = 12'h00C;   // read only

    // control fields
    localparam int CTRL_RUN_BIT    = 0;
    localparam int CTRL_CCA_EN_BIT = 1;

    // limits, upper in the high half
    localparam int LIMIT_UPPER_LSB = 16;
    localparam int LIMIT_LOWER_LSB = 0;

    // status fields
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_OVF_BIT   = 1;    // sticky, write 1 to clear
    localparam int STATUS_LEVEL_LSB = 16;

endpackage

/* rtl/apb_cca_regs.sv */
`timescale 1ns/100ps

module apb_cca_regs (
    input  logic                            clk_80m,
    input  logic                            rst_i,
    // apb slave
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [cca_pkg::APB_ADDR_W-1:0]  paddr_i,
    input  logic [cca_pkg::APB_DATA_W-1:0]  pwdata_i,
    output logic [cca_pkg::APB_DATA_W-1:0]  prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    // status sources
    input  logic                            ovf_i,
    input  logic [cca_pkg::FIFO_LEVEL_W-1:0] fifo_level_i,
    input  logic                            cca_busy_i,
    input  logic                            avg_valid_i,
    input  logic [cca_pkg::POWER_W-1:0]     avg_power_i,
    // controls
    output logic                            run_o,
    output logic                            cca_en_o,
    output logic [cca_pkg::POWER_W-1:0]     upper_limit_o,
    output logic [cca_pkg::POWER_W-1:0]     lower_limit_o
);

    logic                          access;
    logic                          hit_ctrl;
    logic                          hit_limits;
    logic                          hit_status;
    logic                          hit_power;
    logic                          wr_en;
    logic                          ovf_q;
    logic [cca_pkg::POWER_W-1:0]   power_q;

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    assign access     = psel_i & penable_i;
    assign hit_ctrl   = (paddr_i == cca_pkg::REG_CTRL);
    assign hit_limits = (paddr_i == cca_pkg::REG_LIMITS);
    assign hit_status = (paddr_i == cca_pkg::REG_STATUS);
    assign hit_power  = (paddr_i == cca_pkg::REG_POWER);

    assign wr_en      = access & pwrite_i;

    assign pready_o   = 1'b1;   // zero wait states

    // unknown offset, or a write to the read-only power word
    assign pslverr_o  = access &
                        (~(hit_ctrl | hit_limits | hit_status | hit_power) |
                         (pwrite_i & hit_power));

    // ----------------------------------------
    // register state
    // ----------------------------------------
    always_ff @(posedge clk_80m) begin
        if (rst_i) begin
            run_o         <= 1'b0;
            cca_en_o      <= 1'b0;
            upper_limit_o <= '0;
            lower_limit_o <= '0;
            ovf_q         <= 1'b0;
            power_q       <= '0;
        end else begin
            if (wr_en && hit_ctrl) begin
                run_o    <= pwdata_i[cca_pkg::CTRL_RUN_BIT];
                cca_en_o <= pwdata_i[cca_pkg::CTRL_CCA_EN_BIT];
            end
            if (wr_en && hit_limits) begin
                upper_limit_o <= pwdata_i[cca_pkg::LIMIT_UPPER_LSB +: cca_pkg::POWER_W];
                lower_limit_o <= pwdata_i[cca_pkg::LIMIT_LOWER_LSB +: cca_pkg::POWER_W];
            end
            // a new overflow beats a clear in the same cycle
            if (ovf_i) begin
                ovf_q <= 1'b1;
            end else if (wr_en && hit_status && pwdata_i[cca_pkg::STATUS_OVF_BIT]) begin
                ovf_q <= 1'b0;
            end
            if (avg_valid_i) begin
                power_q <= avg_power_i;   // last average for read-back
            end
        end
    end

    // read mux, valid in the access phase
    always_comb begin
        prdata_o = '0;
        if (hit_ctrl) begin
            prdata_o[cca_pkg::CTRL_RUN_BIT]    = run_o;
            prdata_o[cca_pkg::CTRL_CCA_EN_BIT] = cca_en_o;
        end else if (hit_limits) begin
            prdata_o[cca_pkg::LIMIT_UPPER_LSB +: cca_pkg::POWER_W] = upper_limit_o;
            prdata_o[cca_pkg::LIMIT_LOWER_LSB +: cca_pkg::POWER_W] = lower_limit_o;
        end else if (hit_status) begin
            prdata_o[cca_pkg::STATUS_BUSY_BIT] = cca_busy_i;
            prdata_o[cca_pkg::STATUS_OVF_BIT]  = ovf_q;
            prdata_o[cca_pkg::STATUS_LEVEL_LSB +: cca_pkg::FIFO_LEVEL_W] = fifo_level_i;
        end else if (hit_power) begin
            prdata_o[cca_pkg::POWER_W-1:0] = power_q;
        end
    end

    // access phase only ever follows a select
    a_penable_needs_psel: assert property (
        @(posedge clk_80m) disable iff (rst_i) penable_i |-> psel_i
    );

endmodule

/* rtl/rx_sample_fifo.sv */
`timescale 1ns/100ps

module rx_sample_fifo (
    input  logic                                clk_80m,
    input  logic                                rst_i,
    // converter side
    input  logic                                adc_valid_i,
    input  logic                                adc_enable_i_i,
    input  logic                                adc_enable_q_i,
    input  logic signed [cca_pkg::SAMPLE_W-1:0] adc_i_i,
    input  logic signed [cca_pkg::SAMPLE_W-1:0] adc_q_i,
    // drain control
    input  logic                                run_i,
    // to the estimator
    output logic                                smp_valid_o,
    output logic signed [cca_pkg::SAMPLE_W-1:0] smp_i_o,
    output logic signed [cca_pkg::SAMPLE_W-1:0] smp_q_o,
    output logic [cca_pkg::FIFO_LEVEL_W-1:0]    level_o,
    output logic                                ovf_o
);

    logic [2*cca_pkg::SAMPLE_W-1:0]         mem [cca_pkg::FIFO_DEPTH];
    logic [$clog2(cca_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(cca_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic                                   qualified;
    logic                                   full;
    logic                                   empty;
    logic                                   push;
    logic                                   pop;

    // both channels must be live for a usable pair
    assign qualified = adc_valid_i & adc_enable_i_i & adc_enable_q_i;

    assign full  = (level_o == cca_pkg::FIFO_DEPTH);
    assign empty = (level_o == '0);
    assign push  = qualified & ~full;   // dropped when full
    assign pop   = run_i & ~empty;

    // ----------------------------------------
    // pointers and fill level
    // ----------------------------------------
    always_ff @(posedge clk_80m) begin
        if (rst_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            level_o     <= '0;
            smp_valid_o <= 1'b0;
            ovf_o       <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level_o <= level_o + 1'b1;
                2'b01:   level_o <= level_o - 1'b1;
                default: level_o <= level_o;
            endcase
            smp_valid_o <= pop;
            ovf_o       <= qualified & full;   // one pulse per lost sample
        end
    end

    // storage and output payload
    always_ff @(posedge clk_80m) begin
        if (push) begin
            mem[wr_ptr] <= {adc_i_i, adc_q_i};
        end
        if (pop) begin
            {smp_i_o, smp_q_o} <= mem[rd_ptr];
        end
    end

    a_level_in_range: assert property (
        @(posedge clk_80m) disable iff (rst_i) level_o <= cca_pkg::FIFO_DEPTH
    );

endmodule

/* rtl/power_estimator.sv */
`timescale 1ns/100ps

module power_estimator (
    input  logic                                clk_80m,
    input  logic                                rst_i,
    input  logic                                smp_valid_i,
    input  logic signed [cca_pkg::SAMPLE_W-1:0] smp_i_i,
    input  logic signed [cca_pkg::SAMPLE_W-1:0] smp_q_i,
    output logic                                avg_valid_o,
    output logic [cca_pkg::POWER_W-1:0]         avg_power_o
);

    logic signed [2*cca_pkg::SAMPLE_W-1:0]      sq_i;
    logic signed [2*cca_pkg::SAMPLE_W-1:0]      sq_q;
    logic [2*cca_pkg::SAMPLE_W:0]               energy;     // one spare bit for the sum
    logic [2*cca_pkg::SAMPLE_W:0]               energy_shr;
    logic [cca_pkg::POWER_W-1:0]                inst_pwr;

    logic                                       pwr_valid_q;
    logic [cca_pkg::POWER_W-1:0]                pwr_q;

    logic [cca_pkg::POWER_W-1:0]                hist [cca_pkg::WINDOW_LEN];
    logic [cca_pkg::WINDOW_LOG2-1:0]            hist_ptr;   // oldest entry
    logic [cca_pkg::POWER_W+cca_pkg::WINDOW_LOG2-1:0] sum_q;

    // ----------------------------------------
    // stage 1, instantaneous power
    // ----------------------------------------
    assign sq_i       = smp_i_i * smp_i_i;
    assign sq_q       = smp_q_i * smp_q_i;
    assign energy     = {1'b0, sq_i} + {1'b0, sq_q};   // squares are never negative
    assign energy_shr = energy >> cca_pkg::POWER_SHIFT;

    // clip to full scale
    always_comb begin
        if (|energy_shr[2*cca_pkg::SAMPLE_W:cca_pkg::POWER_W]) begin
            inst_pwr = '1;
        end else begin
            inst_pwr = energy_shr[cca_pkg::POWER_W-1:0];
        end
    end

    always_ff @(posedge clk_80m) begin
        if (rst_i) begin
            pwr_valid_q <= 1'b0;
        end else begin
            pwr_valid_q <= smp_valid_i;
        end
    end

    always_ff @(posedge clk_80m) begin
        if (smp_valid_i) begin
            pwr_q <= inst_pwr;
        end
    end

    // ----------------------------------------
    // stage 2, sliding window sum
    // ----------------------------------------
    always_ff @(posedge clk_80m) begin
        if (rst_i) begin
            for (int k = 0; k < cca_pkg::WINDOW_LEN; k++) begin
                hist[k] <= '0;
            end
            hist_ptr    <= '0;
            sum_q       <= '0;
            avg_valid_o <= 1'b0;
        end else begin
            avg_valid_o <= pwr_valid_q;
            if (pwr_valid_q) begin
                // new value in, oldest value out
                sum_q          <= sum_q + pwr_q - hist[hist_ptr];
                hist[hist_ptr] <= pwr_q;
                hist_ptr       <= hist_ptr + 1'b1;
            end
        end
    end

    // divide by window length
    assign avg_power_o = sum_q[cca_pkg::WINDOW_LOG2 +: cca_pkg::POWER_W];

endmodule

/* rtl/cca_decision.sv */
`timescale 1ns/100ps

module cca_decision (
    input  logic                        clk_80m,
    input  logic                        rst_i,
    input  logic                        cca_en_i,
    input  logic [cca_pkg::POWER_W-1:0] upper_limit_i,
    input  logic [cca_pkg::POWER_W-1:0] lower_limit_i,
    input  logic                        avg_valid_i,
    input  logic [cca_pkg::POWER_W-1:0] avg_power_i,
    output logic                        cca_busy_o,
    output logic                        cca_fall_o
);

    logic above_upper;
    logic below_lower;

    assign above_upper = (avg_power_i > upper_limit_i);
    assign below_lower = (avg_power_i < lower_limit_i);

    // ----------------------------------------
    // hysteresis state
    // ----------------------------------------
    always_ff @(posedge clk_80m) begin
        if (rst_i) begin
            cca_busy_o <= 1'b0;
            cca_fall_o <= 1'b0;
        end else begin
            cca_fall_o <= 1'b0;   // single cycle pulse
            if (!cca_en_i) begin
                cca_busy_o <= 1'b0;   // disabled, quiet drop to idle
            end else if (avg_valid_i) begin
                if (!cca_busy_o && above_upper) begin
                    cca_busy_o <= 1'b1;
                end else if (cca_busy_o && below_lower) begin
                    cca_busy_o <= 1'b0;
                    cca_fall_o <= 1'b1;
                end
            end
        end
    end

    // a fall pulse always comes out of the busy state
    a_fall_after_busy: assert property (
        @(posedge clk_80m) disable iff (rst_i) cca_fall_o |-> $past(cca_busy_o)
    );

endmodule

/* rtl/cca_frontend_top.sv */
`timescale 1ns/100ps

module cca_frontend_top (
    input  logic                                clk_80m,
    input  logic                                rst_i,
    // apb register port
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [cca_pkg::APB_ADDR_W-1:0]      paddr_i,
    input  logic [cca_pkg::APB_DATA_W-1:0]      pwdata_i,
    output logic [cca_pkg::APB_DATA_W-1:0]      prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    // rf converter samples
    input  logic                                adc_valid_i,
    input  logic                                adc_enable_i_i,
    input  logic                                adc_enable_q_i,
    input  logic signed [cca_pkg::SAMPLE_W-1:0] adc_i_i,
    input  logic signed [cca_pkg::SAMPLE_W-1:0] adc_q_i,
    // channel state
    output logic                                cca_busy_o,
    output logic                                cca_fall_o
);

    // ----------------------------------------
    // internal wires
    // ----------------------------------------
    logic                                smp_valid;
    logic signed [cca_pkg::SAMPLE_W-1:0] smp_i;
    logic signed [cca_pkg::SAMPLE_W-1:0] smp_q;
    logic [cca_pkg::FIFO_LEVEL_W-1:0]    fifo_level;
    logic                                ovf;
    logic                                avg_valid;
    logic [cca_pkg::POWER_W-1:0]         avg_power;
    logic                                run;
    logic                                cca_en;
    logic [cca_pkg::POWER_W-1:0]         upper_limit;
    logic [cca_pkg::POWER_W-1:0]         lower_limit;

    rx_sample_fifo u_fifo (
        .clk_80m        (clk_80m),
        .rst_i          (rst_i),
        .adc_valid_i    (adc_valid_i),
        .adc_enable_i_i (adc_enable_i_i),
        .adc_enable_q_i (adc_enable_q_i),
        .adc_i_i        (adc_i_i),
        .adc_q_i        (adc_q_i),
        .run_i          (run),
        .smp_valid_o    (smp_valid),
        .smp_i_o        (smp_i),
        .smp_q_o        (smp_q),
        .level_o        (fifo_level),
        .ovf_o          (ovf)
    );

    power_estimator u_power (
        .clk_80m     (clk_80m),
        .rst_i       (rst_i),
        .smp_valid_i (smp_valid),
        .smp_i_i     (smp_i),
        .smp_q_i     (smp_q),
        .avg_valid_o (avg_valid),
        .avg_power_o (avg_power)
    );

    cca_decision u_decision (
        .clk_80m       (clk_80m),
        .rst_i         (rst_i),
        .cca_en_i      (cca_en),
        .upper_limit_i (upper_limit),
        .lower_limit_i (lower_limit),
        .avg_valid_i   (avg_valid),
        .avg_power_i   (avg_power),
        .cca_busy_o    (cca_busy_o),
        .cca_fall_o    (cca_fall_o)   // agc fall equivalent
    );

    apb_cca_regs u_regs (
        .clk_80m       (clk_80m),
        .rst_i         (rst_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .ovf_i         (ovf),
        .fifo_level_i  (fifo_level),
        .cca_busy_i    (cca_busy_o),
        .avg_valid_i   (avg_valid),
        .avg_power_i   (avg_power),
        .run_o         (run),
        .cca_en_o      (cca_en),
        .upper_limit_o (upper_limit),
        .lower_limit_o (lower_limit)
    );

endmodule

/* bench/tb_cca_frontend.sv */
`timescale 1ns/100ps

module tb_cca_frontend;

    localparam string STIM_FILE       = "bench/cca_stimulus.txt";
    localparam int    CYCLES_PER_LINE = 64;
    localparam int    PIPE_CYCLES     = 5;   // pop, square, sum, decision, one spare

    logic                                clk_80m;
    logic                                rst_i;
    logic                                psel_i;
    logic                                penable_i;
    logic                                pwrite_i;
    logic [cca_pkg::APB_ADDR_W-1:0]      paddr_i;
    logic [cca_pkg::APB_DATA_W-1:0]      pwdata_i;
    logic [cca_pkg::APB_DATA_W-1:0]      prdata_o;
    logic                                pready_o;
    logic                                pslverr_o;
    logic                                adc_valid_i;
    logic                                adc_enable_i_i;
    logic                                adc_enable_q_i;
    logic signed [cca_pkg::SAMPLE_W-1:0] adc_i_i;
    logic signed [cca_pkg::SAMPLE_W-1:0] adc_q_i;
    logic                                cca_busy_o;
    logic                                cca_fall_o;

    int              cycle_cnt;
    int              cycle_limit;
    int              fall_total;
    int              fall_base;
    int              test_errs;
    int              pass_cnt;
    int              fail_cnt;
    bit              in_test;
    bit              run_set;   // last run bit written to CTRL
    logic [8*32-1:0] test_name;

    cca_frontend_top u_dut (
        .clk_80m        (clk_80m),
        .rst_i          (rst_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .adc_valid_i    (adc_valid_i),
        .adc_enable_i_i (adc_enable_i_i),
        .adc_enable_q_i (adc_enable_q_i),
        .adc_i_i        (adc_i_i),
        .adc_q_i        (adc_q_i),
        .cca_busy_o     (cca_busy_o),
        .cca_fall_o     (cca_fall_o)
    );

    initial begin
        clk_80m = 1'b0;
        forever #10 clk_80m = ~clk_80m;
    end

    // ----------------------------------------
    // cycle limit and fall pulse counter
    // ----------------------------------------
    always @(posedge clk_80m) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cca_fall_o) begin
            fall_total <= fall_total + 1;
        end
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("run stopped after %0d cycles, the DUT did not finish in time", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %0s %0s: expected %h, actual %h", test_name, what, expected, actual);
            test_errs++;
        end
    endtask

    // one apb transfer through its setup and access phases
    task automatic apb_access(input logic wr, input logic [cca_pkg::APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk_80m);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk_80m);
        penable_i <= 1'b1;
        @(negedge clk_80m);
        check_value("pready", 32'h1, pready_o);   // zero wait states
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_80m);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    // en bit 0 is the I enable, bit 1 the Q enable
    task automatic push_samples(input logic [15:0] si, input logic [15:0] sq,
                                input logic [1:0] en, input int count);
        for (int k = 0; k < count; k++) begin
            @(posedge clk_80m);
            adc_valid_i    <= 1'b1;
            adc_enable_i_i <= en[0];
            adc_enable_q_i <= en[1];
            adc_i_i        <= si;
            adc_q_i        <= sq;
        end
        @(posedge clk_80m);
        adc_valid_i    <= 1'b0;
        adc_enable_i_i <= 1'b0;
        adc_enable_q_i <= 1'b0;
    endtask

    // poll STATUS until the fifo is empty, then let the pipeline flush
    task automatic wait_drained();
        logic [31:0]                      rdata;
        logic                             err;
        logic [cca_pkg::FIFO_LEVEL_W-1:0] level;
        level = '1;
        while (level != '0) begin
            apb_access(1'b0, cca_pkg::REG_STATUS, 32'h0, rdata, err);
            level = rdata[cca_pkg::STATUS_LEVEL_LSB +: cca_pkg::FIFO_LEVEL_W];
        end
        repeat (PIPE_CYCLES) @(posedge clk_80m);
    endtask

    task automatic close_test();
        if (in_test || test_errs != 0) begin
            if (test_errs == 0) begin
                pass_cnt++;
                $display("test %0s ok", test_name);
            end else begin
                fail_cnt++;
                $display("test %0s failed with %0d errors", test_name, test_errs);
            end
        end
    endtask

    function automatic int count_lines();
        int              fd;
        int              code;
        int              n;
        logic [8*128-1:0] line;
        n  = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            n = -1;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    n++;
                end
            end
            $fclose(fd);
        end
        return n;
    endfunction

    // ----------------------------------------
    // command interpreter
    // ----------------------------------------
    task automatic run_stimulus();
        int               fd;
        int               code;
        int               count;
        bit               done;
        logic [8*32-1:0]  cmd;
        logic [8*128-1:0] line;
        logic [31:0]      arg_a;
        logic [31:0]      arg_b;
        logic [31:0]      rdata;
        logic [1:0]       en;
        logic             err;
        fd   = $fopen(STIM_FILE, "r");
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": code = $fgets(line, fd);   // rest of a comment line
                    "T": begin
                        close_test();
                        code      = $fscanf(fd, "%s", test_name);
                        test_errs = 0;
                        in_test   = 1'b1;
                        fall_base = fall_total;
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h", arg_a, arg_b);
                        apb_access(1'b1, arg_a[cca_pkg::APB_ADDR_W-1:0], arg_b, rdata, err);
                        check_value("pslverr on write", 32'h0, err);
                        if (arg_a[cca_pkg::APB_ADDR_W-1:0] == cca_pkg::REG_CTRL) begin
                            run_set = arg_b[cca_pkg::CTRL_RUN_BIT];
                        end
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", arg_a, arg_b);
                        if (run_set) begin
                            wait_drained();
                        end
                        apb_access(1'b0, arg_a[cca_pkg::APB_ADDR_W-1:0], 32'h0, rdata, err);
                        check_value("pslverr on read", 32'h0, err);
                        check_value($sformatf("read %h", arg_a[11:0]), arg_b, rdata);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h", arg_a);
                        // all ones, so a write that lands anyway shows on read-back
                        apb_access(1'b1, arg_a[cca_pkg::APB_ADDR_W-1:0], 32'hFFFF_FFFF,
                                   rdata, err);
                        check_value($sformatf("pslverr at %h", arg_a[11:0]), 32'h1, err);
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %h %h %d", arg_a, arg_b, en, count);
                        push_samples(arg_a[15:0], arg_b[15:0], en, count);
                    end
                    "N": begin
                        code = $fscanf(fd, "%d", count);
                        repeat (count) @(posedge clk_80m);
                    end
                    "B": begin
                        code = $fscanf(fd, "%h", arg_b);
                        if (run_set) begin
                            wait_drained();
                        end
                        @(negedge clk_80m);
                        check_value("cca busy", arg_b, cca_busy_o);
                    end
                    "F": begin
                        code = $fscanf(fd, "%d", count);
                        if (run_set) begin
                            wait_drained();
                        end
                        @(negedge clk_80m);
                        check_value("fall pulses", count, fall_total - fall_base);
                    end
                    default: begin
                        $display("unknown command %0s in the stimulus file", cmd);
                        test_errs++;
                        code = $fgets(line, fd);
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int nlines;
        rst_i          = 1'b1;
        psel_i         = 1'b0;
        penable_i      = 1'b0;
        pwrite_i       = 1'b0;
        paddr_i        = '0;
        pwdata_i       = '0;
        adc_valid_i    = 1'b0;
        adc_enable_i_i = 1'b0;
        adc_enable_q_i = 1'b0;
        adc_i_i        = '0;
        adc_q_i        = '0;
        test_name      = "setup";
        in_test        = 1'b0;
        run_set        = 1'b0;
        test_errs      = 0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        fall_base      = 0;
        nlines         = count_lines();
        if (nlines < 0) begin
            $display("cannot open %0s, nothing to run", STIM_FILE);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            cycle_limit = nlines * CYCLES_PER_LINE + 16;   // lines plus reset
            repeat (5) @(posedge clk_80m);
            rst_i <= 1'b0;
            run_stimulus();
            close_test();
            $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule

/* bench/cca_stimulus.txt */
# T name | W off data | R off expected | E off | B busy | F falls (dec) | N cycles (dec)
# S i q en count(dec), en bit 0 = I enable, bit 1 = Q enable, other fields hex
T reset_and_access
R 000 00000000
R 004 00000000
R 008 00000000
R 00C 00000000
W 000 00000003
R 000 00000003
W 004 12345678
R 004 12345678
E 010
E 00C
R 00C 00000000
W 000 00000000
W 004 00000000
R 004 00000000
# i = 0x4000 gives (2^28 >> 15) = 0x2000 per sample
T qualify_and_average
W 000 00000001
S 4000 0000 3 16
R 00C 00002000
S 7000 7000 1 5
S 7000 7000 2 5
R 00C 00002000
R 008 00000000
T busy_rise
W 004 10000800
W 000 00000003
S 4000 0000 3 4
B 1
W 000 00000001
S 4000 0000 3 4
B 0
F 0
# 8 x 0x1000 and 8 x 0x0800 average to 0x0C00
T hysteresis_fall
W 000 00000003
S 4000 0000 3 1
B 1
S 2000 2000 3 8
S 2000 0000 3 8
R 00C 00000C00
B 1
F 0
S 0000 0000 3 16
B 0
F 1
R 00C 00000000
T overflow
W 000 00000000
S 1000 1000 3 20
R 008 00100002
W 008 00000002
R 008 00100000
W 000 00000001
R 008 00000000
R 00C 00000400
N 4

/* flist.f */
rtl/cca_pkg.sv
rtl/apb_cca_regs.sv
rtl/rx_sample_fifo.sv
rtl/power_estimator.sv
rtl/cca_decision.sv
rtl/cca_frontend_top.sv
bench/tb_cca_frontend.sv
